//--- project.f
design/adc_pkg.sv
design/adc_config_regs.sv
design/adc_convert_seq.sv
design/adc_serial_reader.sv
design/adc_subsystem_top.sv
verification/adc_model.sv
verification/adc_subsystem_asserts.sv
verification/adc_subsystem_tb.sv

//--- Bender.yml
package:
  name: adc_subsystem

sources:
  - design/adc_pkg.sv
  - design/adc_config_regs.sv
  - design/adc_convert_seq.sv
  - design/adc_serial_reader.sv
  - design/adc_subsystem_top.sv
  - target: test
    files:
      - verification/adc_model.sv
      - verification/adc_subsystem_asserts.sv
      - verification/adc_subsystem_tb.sv

//--- verification/adc_subsystem_tb.sv
`timescale 1ns/100ps

module adc_subsystem_tb;

	localparam int W_OUT   = 18;
	localparam int N_CHAN  = 8;
	localparam int T_IDLE  = 200;  // quiet clocks after reset
	localparam int N_GAPS  = 4;    // pulse gaps timed per cycle setting
	localparam int T_QUIET = 260;  // two long cycles without a pulse
	localparam int TIMEOUT = T_IDLE + (N_GAPS + 1) * 2 * 130 + 3 * 130 + 2 * T_QUIET + 500;

	logic                    clk_in = 1'b0;
	logic                    reset_in = 1'b1;
	logic                    cfg_wr = 1'b0;
	logic                    cfg_addr = 1'b0;
	adc_pkg::cfg_word_t      cfg_data = '0;
	logic                    busy_in, data_a_in, data_b_in;
	logic [2:0]              os_out;
	logic                    convst_out, reset_out, sclk_out, n_cs_out;
	logic [N_CHAN-1:0]       sample_valid;
	logic signed [W_OUT-1:0] sample_a, sample_b;

	logic [W_OUT-1:0] exp_tab [8];  // expected channel words
	int   seed = 32'hdeb1;
	int   err_cnt = 0;
	int   cyc = 0;
	int   min_exp = 85;             // expected minimum pulse spacing
	logic gap_on = 1'b1;            // spacing check enabled
	int   last_conv = -1;
	int   n_conv = 0;
	int   n_valid = 0;
	int   next_lane = 0;
	int   cs_len = 0;
	int   sclk_falls = 0;           // falling sclk edges since reset
	int   n_reads = 0;              // completed chip select windows
	logic convst_d = 1'b1;
	logic n_cs_d = 1'b1;

	always #2 clk_in = ~clk_in;  // 4 ns period

	adc_subsystem_top #(.W_OUT(W_OUT), .N_CHAN(N_CHAN)) UUT (.*);

	adc_model #(.W_OUT(W_OUT)) adc (
		.clk_in (clk_in), .rst (reset_out), .convst_n (convst_out), .cs_n (n_cs_out),
		.sclk (sclk_out), .busy (busy_in), .dout_a (data_a_in), .dout_b (data_b_in)
	);

	bind adc_subsystem_top adc_subsystem_asserts #(.N_CHAN(N_CHAN)) u_asserts (
		.clk_in (clk_in), .reset_in (reset_in), .convst_out (convst_out),
		.n_cs_out (n_cs_out), .busy_in (busy_in), .sample_valid (sample_valid)
	);

	task automatic flag_error(input string msg);
		err_cnt++;
		$display("%s", msg);
	endtask

	////////////////////////////////////////////////////////////
	// pin monitor, sampled on the falling edge
	////////////////////////////////////////////////////////////

	always @(negedge clk_in) begin
		cyc <= cyc + 1;
		convst_d <= convst_out;
		n_cs_d <= n_cs_out;
		if (cyc > TIMEOUT) begin
			$display("timeout: run did not finish within %0d clocks", TIMEOUT);
			$display("tests failed");
			$finish;
		end else if (!reset_in) begin
			if (!convst_out) begin
				assert (convst_d) else flag_error("convst_out stayed low for two clocks");
				if (gap_on && last_conv >= 0)
					assert (cyc - last_conv >= min_exp) else flag_error($sformatf(
						"Mismatch convst_out spacing: got %h expected >= %h",
						cyc - last_conv, min_exp));
				last_conv <= cyc;
				n_conv <= n_conv + 1;
			end
			if (sample_valid != '0) begin
				assert (sample_valid == N_CHAN'(1) << next_lane) else flag_error($sformatf(
					"Mismatch sample_valid: got %h expected %h",
					sample_valid, N_CHAN'(1) << next_lane));
				assert (sample_a == exp_tab[next_lane % 4]) else flag_error($sformatf(
					"Mismatch sample_a: got %h expected %h", sample_a, exp_tab[next_lane % 4]));
				assert (sample_b == exp_tab[next_lane % 4 + 4]) else flag_error($sformatf(
					"Mismatch sample_b: got %h expected %h", sample_b,
					exp_tab[next_lane % 4 + 4]));
				next_lane <= (next_lane + 1) % N_CHAN;  // lanes cycle 0..7 across reads
				n_valid <= n_valid + 1;
			end
			if (!n_cs_out) begin
				cs_len <= cs_len + 1;
				if (n_cs_d)
					assert (busy_in) else flag_error("n_cs_out fell while busy_in was low");
			end else begin
				assert (sclk_out === 1'b1) else flag_error(
					"sclk_out was not high while n_cs_out was high");
				if (!n_cs_d) begin
					assert (cs_len == 4 * W_OUT) else flag_error($sformatf(
						"Mismatch n_cs_out low clocks: got %h expected %h", cs_len, 4 * W_OUT));
					assert (sclk_falls == 4 * W_OUT * (n_reads + 1)) else flag_error($sformatf(
						"Mismatch sclk_out falls: got %h expected %h", sclk_falls,
						4 * W_OUT * (n_reads + 1)));
					cs_len <= 0;
					n_reads <= n_reads + 1;
				end
			end
		end
	end

	// one falling sclk per bit, only inside the window
	always @(negedge sclk_out) begin
		if (!reset_in) begin
			assert (!n_cs_out) else flag_error("sclk_out fell while n_cs_out was high");
			sclk_falls <= sclk_falls + 1;
		end
	end

	////////////////////////////////////////////////////////////
	// host writes and waits
	////////////////////////////////////////////////////////////

	function automatic adc_pkg::cfg_word_t ctrl_word(input logic run, input logic restart,
			input logic [2:0] os);
		adc_pkg::cfg_word_t w;
		w = '0;
		w.ctrl.run = run;
		w.ctrl.restart = restart;
		w.ctrl.os = os;
		return w;
	endfunction

	task automatic write_reg(input logic addr, input adc_pkg::cfg_word_t data);
		@(negedge clk_in);
		cfg_wr = 1'b1;
		cfg_addr = addr;
		cfg_data = data;
		@(negedge clk_in);
		cfg_wr = 1'b0;  // one clock strobe
	endtask

	task automatic wait_conv(input int limit);
		int n;
		n = 0;
		while (convst_out !== 1'b0 && n < limit) begin
			@(negedge clk_in);
			n++;
		end
		assert (convst_out === 1'b0) else flag_error($sformatf(
			"no convert pulse within %0d clocks", limit));
		@(negedge clk_in);  // step past the pulse
	endtask

	task automatic quiet(input int len, input string what);
		repeat (len) begin
			@(negedge clk_in);
			assert (convst_out) else flag_error(what);
		end
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic test_idle();
		repeat (T_IDLE) begin
			@(negedge clk_in);
			assert (convst_out && n_cs_out && sclk_out && sample_valid == '0)
				else flag_error("pins left idle levels with run clear");
			assert (reset_out === 1'b0) else flag_error($sformatf(
				"Mismatch reset_out: got %h expected %h", reset_out, 1'b0));
		end
		assert (os_out == 3'd0) else flag_error($sformatf(
			"Mismatch os_out: got %h expected %h", os_out, 3'd0));
	endtask

	task automatic test_spacing();
		write_reg(adc_pkg::ADDR_CTRL, ctrl_word(1'b1, 1'b0, 3'd0));
		wait_conv(4);  // idle to start in one clock
		repeat (N_GAPS) wait_conv(85 + 10);
		write_reg(adc_pkg::ADDR_CYCLE, 8'd120);
		wait_conv(130);  // gap in flight may use the old length
		min_exp = 120;
		repeat (N_GAPS) wait_conv(120 + 10);
	endtask

	task automatic test_samples();
		int start;
		int n;
		start = n_valid;
		n = 0;
		while (n_valid < start + N_CHAN && n < 3 * 130) begin
			@(negedge clk_in);
			n++;
		end
		assert (n_valid >= start + N_CHAN) else flag_error("too few sample_valid pulses");
	endtask

	task automatic test_stop();
		write_reg(adc_pkg::ADDR_CTRL, ctrl_word(1'b1, 1'b0, 3'd5));
		assert (os_out == 3'd5) else flag_error($sformatf(
			"Mismatch os_out: got %h expected %h", os_out, 3'd5));
		wait_conv(130);
		repeat (10) @(negedge clk_in);
		write_reg(adc_pkg::ADDR_CTRL, ctrl_word(1'b0, 1'b0, 3'd5));
		quiet(T_QUIET, "convert pulse after run was cleared");
		write_reg(adc_pkg::ADDR_CTRL, ctrl_word(1'b1, 1'b0, 3'd5));
		wait_conv(4);
		gap_on = 1'b0;  // restart cuts the cycle short
		repeat (10) @(negedge clk_in);
		write_reg(adc_pkg::ADDR_CTRL, ctrl_word(1'b0, 1'b1, 3'd5));
		write_reg(adc_pkg::ADDR_CTRL, ctrl_word(1'b1, 1'b0, 3'd5));
		wait_conv(4);  // back in idle, so no cycle wait
		write_reg(adc_pkg::ADDR_CTRL, ctrl_word(1'b0, 1'b1, 3'd5));
		quiet(T_QUIET, "convert pulse after restart");
	endtask

	initial begin
		for (int c = 0; c < 8; c++) begin
			exp_tab[c] = W_OUT'($random(seed));
			adc.tab[c] = exp_tab[c];
		end
		repeat (4) begin
			@(negedge clk_in);
			assert (reset_out === 1'b1) else flag_error($sformatf(
				"Mismatch reset_out: got %h expected %h", reset_out, 1'b1));
		end
		reset_in = 1'b0;
		test_idle();
		test_spacing();
		test_samples();
		test_stop();
		$display("errors: %0d, convert pulses: %0d, samples: %0d", err_cnt, n_conv, n_valid);
		if (err_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- verification/adc_subsystem_asserts.sv
`timescale 1ns/100ps

module adc_subsystem_asserts #(
	parameter int N_CHAN = 8
) (
	input logic              clk_in,
	input logic              reset_in,
	input logic              convst_out,
	input logic              n_cs_out,
	input logic              busy_in,
	input logic [N_CHAN-1:0] sample_valid
);

	// convert start is a single clock low
	a_convst_single: assert property (@(posedge clk_in) disable iff (reset_in)
		!convst_out |=> convst_out)
		else $error("convst_out low for two clocks in a row");

	// a read only opens during a conversion
	a_cs_in_busy: assert property (@(posedge clk_in) disable iff (reset_in)
		$fell(n_cs_out) |-> busy_in)
		else $error("n_cs_out fell while busy_in was low");

	a_valid_onehot: assert property (@(posedge clk_in) disable iff (reset_in)
		$onehot0(sample_valid))
		else $error("sample_valid has more than one bit set");

endmodule

//--- verification/adc_model.sv
`timescale 1ns/100ps

module adc_model #(
	parameter int W_OUT = 18  // bits per channel word
) (
	input  logic clk_in,
	input  logic rst,         // adc reset pin
	input  logic convst_n,    // convert start, active low
	input  logic cs_n,        // chip select, active low
	input  logic sclk,        // serial clock from the controller
	output logic busy,
	output logic dout_a,      // channels 0..3
	output logic dout_b       // channels 4..7
);

	localparam int T_BUSY = 40;  // conversion time in clocks

	logic [W_OUT-1:0] tab [8];   // channel words, loaded by the test
	int               busy_cnt = 0;
	int               bit_idx = 0;

	initial begin
		dout_a = 1'b0;
		dout_b = 1'b0;
	end

	assign busy = (busy_cnt != 0);

	// busy rises the clock after convert start
	always @(posedge clk_in) begin
		if (rst)
			busy_cnt <= 0;
		else if (!convst_n)
			busy_cnt <= T_BUSY;  // reload, also on a start during busy
		else if (busy_cnt != 0)
			busy_cnt <= busy_cnt - 1;
	end

	////////////////////////////////////////////////////////////
	// serial data, one bit per falling sclk
	////////////////////////////////////////////////////////////

	always @(negedge sclk or posedge cs_n) begin
		if (cs_n) begin
			bit_idx = 0;  // frame ends with chip select
		end else if (bit_idx < 4 * W_OUT) begin
			dout_a <= tab[bit_idx / W_OUT][W_OUT - 1 - bit_idx % W_OUT];      // msb first
			dout_b <= tab[bit_idx / W_OUT + 4][W_OUT - 1 - bit_idx % W_OUT];
			bit_idx = bit_idx + 1;
		end
	end

endmodule

//--- design/adc_subsystem_top.sv
`timescale 1ns/100ps

module adc_subsystem_top #(
	parameter int W_OUT  = 18,  // sample width
	parameter int N_CHAN = 8    // valid lanes, at most adc_pkg::N_CHAN_RD
) (
	input  logic                        clk_in,
	input  logic                        reset_in,
	// host writes
	input  logic                        cfg_wr,
	input  logic                        cfg_addr,
	input  adc_pkg::cfg_word_t          cfg_data,
	// adc pins
	input  logic                        busy_in,
	input  logic                        data_a_in,
	input  logic                        data_b_in,
	output logic [adc_pkg::OS_W-1:0]    os_out,
	output logic                        convst_out,
	output logic                        reset_out,
	output logic                        sclk_out,
	output logic                        n_cs_out,
	// samples
	output logic [N_CHAN-1:0]           sample_valid,
	output logic signed [W_OUT-1:0]     sample_a,
	output logic signed [W_OUT-1:0]     sample_b
);

	logic                        run;        // regs to convert sequencer
	logic                        restart;
	logic [adc_pkg::CYCLE_W-1:0] min_cycle;
	logic [adc_pkg::OS_W-1:0]    os;

	assign os_out    = os;        // straight to the oversampling pins
	assign reset_out = reset_in;  // adc reset follows system reset

	////////////////////////////////////////////////////////////
	// instances
	////////////////////////////////////////////////////////////

	adc_config_regs u_regs (
		.clk_in    (clk_in),
		.reset_in  (reset_in),
		.cfg_wr    (cfg_wr),
		.cfg_addr  (cfg_addr),
		.cfg_data  (cfg_data),
		.run       (run),
		.os        (os),
		.min_cycle (min_cycle),
		.restart   (restart)
	);

	adc_convert_seq u_convert (
		.clk_in     (clk_in),
		.reset_in   (reset_in),
		.run        (run),
		.restart    (restart),
		.min_cycle  (min_cycle),
		.busy_in    (busy_in),
		.convst_out (convst_out)
	);

	adc_serial_reader #(
		.W_OUT  (W_OUT),
		.N_CHAN (N_CHAN)
	) u_reader (
		.clk_in       (clk_in),
		.reset_in     (reset_in),
		.busy_in      (busy_in),
		.data_a_in    (data_a_in),
		.data_b_in    (data_b_in),
		.n_cs_out     (n_cs_out),
		.sclk_out     (sclk_out),
		.sample_valid (sample_valid),
		.sample_a     (sample_a),
		.sample_b     (sample_b)
	);

endmodule

//--- design/adc_serial_reader.sv
`timescale 1ns/100ps

module adc_serial_reader #(
	parameter int W_OUT  = 18,  // bits per sample
	parameter int N_CHAN = 8    // valid lanes presented
) (
	input  logic                     clk_in,
	input  logic                     reset_in,
	input  logic                     busy_in,       // adc conversion busy
	input  logic                     data_a_in,     // serial line a, channels 0..3
	input  logic                     data_b_in,     // serial line b, channels 4..7
	output logic                     n_cs_out,      // active low chip select
	output logic                     sclk_out,      // gated serial clock, idles high
	output logic [N_CHAN-1:0]        sample_valid,  // one-hot lane marker
	output logic signed [W_OUT-1:0]  sample_a,      // line a shift register
	output logic signed [W_OUT-1:0]  sample_b       // line b shift register
);

	localparam int N_HALF    = adc_pkg::N_CHAN_RD / 2;     // samples per line per read
	localparam int RD_LENGTH = W_OUT * N_HALF;             // bits per line per read
	localparam int W_CNT     = $clog2(RD_LENGTH + 1);
	localparam logic USE_BANK = (N_CHAN > N_HALF);         // upper lanes in use

	localparam logic [1:0] RD_IDLE = 2'd0;  // wait for busy
	localparam logic [1:0] RD_READ = 2'd1;  // chip select low, shifting
	localparam logic [1:0] RD_WAIT = 2'd2;  // wait for busy to drop

	logic [1:0]                   rd_state;
	logic [1:0]                   rd_next;
	logic [W_CNT-1:0]             rd_cnt;      // bits shifted so far
	logic                         rd_bank;     // selects lower or upper valid lanes
	logic [adc_pkg::N_CHAN_RD-1:0] valid_full;

	////////////////////////////////////////////////////////////
	// read state machine
	////////////////////////////////////////////////////////////

	always_comb begin
		rd_next = rd_state;
		case (rd_state)
			RD_IDLE: if (busy_in) rd_next = RD_READ;
			RD_READ: if (rd_cnt == W_CNT'(RD_LENGTH)) rd_next = RD_WAIT;
			RD_WAIT: if (!busy_in) rd_next = RD_IDLE;
			default: rd_next = RD_IDLE;
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			rd_state <= RD_IDLE;
			rd_bank  <= 1'b0;
		end else begin
			rd_state <= rd_next;
			if (USE_BANK && (rd_state == RD_READ) && (rd_next == RD_WAIT))
				rd_bank <= ~rd_bank;  // alternate lane banks per read
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in || (rd_state != rd_next)) begin
			rd_cnt <= '0;
		end else if (rd_state == RD_READ) begin
			rd_cnt <= rd_cnt + 1'b1;
		end
	end

	// low for exactly RD_LENGTH clocks, counts 0 .. RD_LENGTH-1
	assign n_cs_out = !((rd_state == RD_READ) && (rd_cnt < W_CNT'(RD_LENGTH)));
	assign sclk_out = clk_in | n_cs_out;  // held high outside the read

	////////////////////////////////////////////////////////////
	// shift registers and valid lanes
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (!n_cs_out) begin
			sample_a <= {sample_a[W_OUT-2:0], data_a_in};  // msb first
			sample_b <= {sample_b[W_OUT-2:0], data_b_in};
		end
	end

	// lane k+N_HALF repeats lane k on the next read
	for (genvar k = 0; k < N_HALF; k++) begin : g_valid
		localparam logic [W_CNT-1:0] HIT = W_CNT'(W_OUT * (k + 1));
		logic hit;  // sample k complete on both lines
		assign hit = (rd_state == RD_READ) && (rd_cnt == HIT);
		assign valid_full[k]          = hit && !rd_bank;
		assign valid_full[k + N_HALF] = hit && rd_bank;
	end

	assign sample_valid = valid_full[N_CHAN-1:0];

endmodule

//--- design/adc_convert_seq.sv
`timescale 1ns/100ps

module adc_convert_seq (
	input  logic                        clk_in,
	input  logic                        reset_in,
	input  logic                        run,         // keep converting while high
	input  logic                        restart,     // force back to idle
	input  logic [adc_pkg::CYCLE_W-1:0] min_cycle,   // min clocks in converting state
	input  logic                        busy_in,     // adc conversion busy
	output logic                        convst_out   // active low convert start
);

	localparam logic [1:0] CV_IDLE  = 2'd0;  // wait for run
	localparam logic [1:0] CV_START = 2'd1;  // convert start pulse
	localparam logic [1:0] CV_CONV  = 2'd2;  // wait out the conversion

	logic [1:0]                  cv_state;
	logic [1:0]                  cv_next;
	logic [adc_pkg::CYCLE_W-1:0] cv_cnt;      // clocks spent in current state
	logic                        cycle_done;  // min time elapsed and adc idle

	assign cycle_done = (cv_cnt >= min_cycle) && !busy_in;

	////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////

	always_comb begin
		cv_next = cv_state;  // hold by default
		case (cv_state)
			CV_IDLE: begin
				if (run)
					cv_next = CV_START;
			end
			CV_START: begin
				cv_next = CV_CONV;  // one clock low only
			end
			CV_CONV: begin
				if (cycle_done)
					cv_next = run ? CV_START : CV_IDLE;
			end
			default: begin
				cv_next = CV_IDLE;
			end
		endcase
		if (restart)
			cv_next = CV_IDLE;  // overrides everything
	end

	////////////////////////////////////////////////////////////
	// state and cycle counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			cv_state <= CV_IDLE;
		end else begin
			cv_state <= cv_next;
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in || (cv_state != cv_next)) begin
			cv_cnt <= '0;  // clear on every state change
		end else if (cv_cnt != '1) begin
			cv_cnt <= cv_cnt + 1'b1;  // saturate on long busy
		end
	end

	assign convst_out = (cv_state != CV_START);

endmodule

//--- design/adc_config_regs.sv
`timescale 1ns/100ps

module adc_config_regs (
	input  logic                               clk_in,
	input  logic                               reset_in,
	input  logic                               cfg_wr,     // one-clock write strobe
	input  logic                               cfg_addr,   // register select
	input  adc_pkg::cfg_word_t                 cfg_data,   // write word
	output logic                               run,        // continuous conversion enable
	output logic [adc_pkg::OS_W-1:0]           os,         // oversampling code
	output logic [adc_pkg::CYCLE_W-1:0]        min_cycle,  // min clocks between convert pulses
	output logic                               restart     // one-clock pulse to convert sequencer
);

	////////////////////////////////////////////////////////////
	// write decode
	////////////////////////////////////////////////////////////

	logic wr_ctrl;   // write to control register
	logic wr_cycle;  // write to cycle register

	assign wr_ctrl  = cfg_wr && (cfg_addr == adc_pkg::ADDR_CTRL);
	assign wr_cycle = cfg_wr && (cfg_addr == adc_pkg::ADDR_CYCLE);

	////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			run       <= 1'b0;
			os        <= '0;
			min_cycle <= adc_pkg::MIN_T_CYCLE_RESET;
		end else begin
			if (wr_ctrl) begin
				run <= cfg_data.ctrl.run;       // ctrl view of the word
				os  <= cfg_data.ctrl.os;
			end
			if (wr_cycle) begin
				min_cycle <= cfg_data.cycle;    // cycle view of the word
			end
		end
	end

	// restart bit is not stored, only pulsed
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			restart <= 1'b0;
		end else begin
			restart <= wr_ctrl && cfg_data.ctrl.restart; // high for one clock
		end
	end

endmodule

//--- design/adc_pkg.sv
package adc_pkg;

	////////////////////////////////////////////////////////////
	// device and register constants
	////////////////////////////////////////////////////////////

	localparam int N_CHAN_RD = 8;                   // channels per conversion on the device
	localparam int OS_W      = 3;                   // oversampling code width
	localparam int CYCLE_W   = 8;                   // cycle length width

	localparam logic ADDR_CTRL  = 1'b0;             // run, restart and os
	localparam logic ADDR_CYCLE = 1'b1;             // minimum cycle length

	localparam logic [CYCLE_W-1:0] MIN_T_CYCLE_RESET = 8'd85; // clocks per conversion at reset

	////////////////////////////////////////////////////////////
	// host write word
	////////////////////////////////////////////////////////////

	// one write word, decoded by address
	typedef union packed {
		struct packed {
			logic            run;                   // continuous conversion enable
			logic            restart;               // one-shot return to idle
			logic [2:0]      spare;                 // unused
			logic [OS_W-1:0] os;                    // oversampling code
		} ctrl;
		logic [CYCLE_W-1:0] cycle;                  // minimum cycle length in clocks
	} cfg_word_t;

endpackage
